/* flist.f */
+incdir+logic
logic/fm_pkg.sv
logic/fm_mmr.sv
logic/fm_slot_regs.sv
logic/fm_timers.sv
logic/fm_ctrl_top.sv
dv/fm_ctrl_properties.sv
dv/fm_ctrl_tb.sv

/* dv/fm_ctrl_tb.sv */
// FM control block testbench
// Table-driven host writes with random gaps, slot scans and timer windows

`timescale 1ns/10ps

`include "fm_config.svh"

module fm_ctrl_tb;

	typedef enum logic [3:0] {
		CHK_NONE, CHK_GLOBALS, CHK_TL, CHK_TL_AT, CHK_DT1MUL, CHK_KSAR,
		CHK_KC, CHK_CONFB, CHK_FLAG_A, CHK_FLAG_B, CHK_FLAGS
	} chk_e;

	typedef struct packed {
		logic        a0;
		logic [7:0]  data;
		logic        wait_busy;
		chk_e        kind;
		logic [15:0] exp;
	} entry_t;

	logic clk = 1'b0;
	logic rst;
	logic [7:0] d_in;
	logic write;
	logic a0;
	logic busy, ne, ct1, ct2, flag_a, flag_b, irq;
	logic [4:0] nfrq, cur_slot, ar;
	logic [7:0] lfo_freq;
	logic [2:0] con, fb, dt1;
	logic [6:0] kc, tl;
	logic [3:0] mul;
	logic [1:0] ks;

	entry_t     tbl[$];
	logic [7:0] last_addr;
	logic [15:0] lfsr;
	int         watch_cycles = 0;

	fm_ctrl_top dut0 (.*);

	always #20 clk = ~clk;

	task automatic report_error(input string msg);
		$display("Error at %0t ns: %s", $time, msg);
		$display("Simulation failed");
		$fatal(1);
	endtask

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	function automatic int next_gap();
		logic [1:0] g;
		lfsr = lfsr_step(lfsr);
		g[0] = lfsr[0];
		lfsr = lfsr_step(lfsr);
		g[1] = lfsr[0];
		return int'(g);
	endfunction

	function automatic logic [7:0] field_value(input chk_e kind);
		case (kind)
			CHK_TL, CHK_TL_AT: return {1'b0, tl};
			CHK_DT1MUL:        return {1'b0, dt1, mul};
			CHK_KSAR:          return {ks, 1'b0, ar};
			CHK_KC:            return {1'b0, kc};
			CHK_CONFB:         return {2'b00, fb, con};
			default:           return 8'h00;
		endcase
	endfunction

	function automatic logic is_operator(input chk_e kind);
		return kind == CHK_TL || kind == CHK_TL_AT || kind == CHK_DT1MUL || kind == CHK_KSAR;
	endfunction

	task automatic add_entry(input logic a, input logic [7:0] d, input logic w,
			input chk_e kind, input logic [15:0] exp);
		entry_t e;
		e = '{a0: a, data: d, wait_busy: w, kind: kind, exp: exp};
		tbl.push_back(e);
	endtask

	// One full scan, target slots hold exp and the rest read zero
	task automatic check_slots(input chk_e kind, input logic [4:0] slot, input logic [7:0] exp);
		int i;
		logic hit;
		logic [7:0] want;
		for (i = 0; i < `FM_SLOTS; i++) begin
			if (kind == CHK_KC || kind == CHK_CONFB)
				hit = (cur_slot[2:0] == slot[2:0]);
			else
				hit = (cur_slot == slot);
			want = hit ? exp : 8'h00;
			if (hit || kind != CHK_TL_AT)
				assert (field_value(kind) == want)
				else report_error($sformatf("slot %0d kind %s read %h, expected %h",
					cur_slot, kind.name(), field_value(kind), want));
			@(negedge clk);
		end
	endtask

	task automatic check_reset_state();
		int i;
		assert (!busy && !flag_a && !flag_b && !irq && {ne, nfrq, ct2, ct1, lfo_freq} == 16'h0)
		else report_error("status or global outputs not zero after reset");
		for (i = 0; i < `FM_SLOTS; i++) begin
			assert ({con, fb, kc, dt1, mul, tl, ks, ar} == '0)
			else report_error($sformatf("slot %0d not zero after reset", cur_slot));
			@(negedge clk);
		end
	endtask

	task automatic wait_flag(input logic is_b, input int value, input int cyc_start);
		int cyc;
		int lo;
		int hi;
		cyc = cyc_start;
		if (is_b) begin
			lo = ((1 << `FM_TIMER_B_W) - value - 1) * `FM_SLOTS * `FM_TIMER_B_PRESCALE;
			hi = ((1 << `FM_TIMER_B_W) - value + 1) * `FM_SLOTS * `FM_TIMER_B_PRESCALE;
		end else begin
			lo = ((1 << `FM_TIMER_A_W) - value - 1) * `FM_SLOTS;
			hi = ((1 << `FM_TIMER_A_W) - value + 1) * `FM_SLOTS;
		end
		while (!(is_b ? flag_b : flag_a)) begin
			@(negedge clk);
			cyc++;
		end
		assert (irq && cyc >= lo && cyc <= hi)
		else report_error($sformatf("timer %s flag after %0d cycles, window %0d to %0d",
			is_b ? "B" : "A", cyc, lo, hi));
	endtask

	task automatic apply_entry(input entry_t e);
		int cyc;
		int busy_cycles;
		a0    <= e.a0;
		d_in  <= e.data;
		write <= 1'b1;
		@(posedge clk);
		write <= 1'b0;
		if (!e.a0)
			last_addr = e.data;
		if (e.wait_busy) begin
			cyc = 0;
			busy_cycles = 0;
			@(negedge clk);
			while (busy) begin
				busy_cycles++;
				@(negedge clk);
				cyc++;
			end
			// Operator writes release the host the cycle after their slot
			if (is_operator(e.kind))
				assert (cur_slot == 5'(last_addr[4:0] + 5'd1))
				else report_error($sformatf("busy fell at slot %0d", cur_slot));
			else
				assert (busy_cycles == 1)
				else report_error($sformatf("busy lasted %0d cycles", busy_cycles));
			case (e.kind)
				CHK_GLOBALS:
					assert ({ne, nfrq, ct2, ct1, lfo_freq} == e.exp)
					else report_error($sformatf("globals %h, expected %h",
						{ne, nfrq, ct2, ct1, lfo_freq}, e.exp));
				CHK_TL, CHK_TL_AT, CHK_DT1MUL, CHK_KSAR, CHK_KC, CHK_CONFB:
					check_slots(e.kind, last_addr[4:0], e.exp[7:0]);
				CHK_FLAG_A: wait_flag(1'b0, int'(e.exp), cyc);
				CHK_FLAG_B: wait_flag(1'b1, int'(e.exp), cyc);
				CHK_FLAGS:
					assert ({flag_a, flag_b, irq} == e.exp[2:0])
					else report_error($sformatf("flags %b, expected %b",
						{flag_a, flag_b, irq}, e.exp[2:0]));
				default: ;
			endcase
		end
	endtask

	// Globals pack as {ne, nfrq, ct2, ct1, lfo_freq}
	task automatic build_table();
		add_entry(0, 8'h0F, 1, CHK_GLOBALS, 16'h0000);
		add_entry(1, 8'h8A, 1, CHK_GLOBALS, 16'hA800);
		add_entry(0, 8'h18, 1, CHK_GLOBALS, 16'hA800);
		add_entry(1, 8'h5C, 1, CHK_GLOBALS, 16'hA85C);
		add_entry(0, 8'h1B, 1, CHK_GLOBALS, 16'hA85C);
		add_entry(1, 8'h80, 1, CHK_GLOBALS, 16'hAA5C);
		add_entry(1, 8'h40, 1, CHK_GLOBALS, 16'hA95C);
		add_entry(0, 8'h6B, 1, CHK_GLOBALS, 16'hA95C);
		add_entry(1, 8'hB3, 1, CHK_TL,      16'h0033);
		add_entry(0, 8'h5D, 1, CHK_GLOBALS, 16'hA95C);
		add_entry(1, 8'hB5, 1, CHK_DT1MUL,  16'h0035);
		add_entry(0, 8'h82, 1, CHK_GLOBALS, 16'hA95C);
		add_entry(1, 8'hF7, 1, CHK_KSAR,    16'h00D7);
		add_entry(0, 8'h2D, 1, CHK_GLOBALS, 16'hA95C);
		add_entry(1, 8'hC4, 1, CHK_KC,      16'h0044);
		add_entry(0, 8'h22, 1, CHK_GLOBALS, 16'hA95C);
		add_entry(1, 8'hEE, 1, CHK_CONFB,   16'h002E);
		// Unmapped channel address is dropped
		add_entry(0, 8'h30, 1, CHK_GLOBALS, 16'hA95C);
		add_entry(1, 8'h77, 1, CHK_NONE,    16'h0000);
		// Second data write lands during the operator wait
		add_entry(0, 8'h71, 1, CHK_GLOBALS, 16'hA95C);
		add_entry(1, 8'h2A, 0, CHK_NONE,    16'h0000);
		add_entry(1, 8'h55, 1, CHK_TL_AT,   16'h002A);
		add_entry(0, 8'h10, 1, CHK_GLOBALS, 16'hA95C);
		add_entry(1, 8'hFF, 1, CHK_NONE,    16'h0000);
		add_entry(0, 8'h11, 1, CHK_GLOBALS, 16'hA95C);
		add_entry(1, 8'h00, 1, CHK_NONE,    16'h0000);
		add_entry(0, 8'h12, 1, CHK_GLOBALS, 16'hA95C);
		add_entry(1, 8'hFE, 1, CHK_NONE,    16'h0000);
		add_entry(0, 8'h14, 1, CHK_GLOBALS, 16'hA95C);
		add_entry(1, 8'h05, 1, CHK_FLAG_A,  16'd1020);
		add_entry(1, 8'h10, 1, CHK_FLAGS,   16'h0000);
		add_entry(1, 8'h0A, 1, CHK_FLAG_B,  16'd254);
		add_entry(1, 8'h20, 1, CHK_FLAGS,   16'h0000);
	endtask

	initial begin
		wait (watch_cycles > 0);
		repeat (watch_cycles) @(posedge clk);
		$display("Timeout: the run did not finish within %0d cycles", watch_cycles);
		$display("Simulation failed");
		$fatal(1);
	end

	initial begin
		int i;
		int gap;
		logic no_wait;
		rst   = 1'b1;
		write = 1'b0;
		a0    = 1'b0;
		d_in  = 8'h00;
		lfsr  = 16'd3567;
		last_addr = 8'h00;
		build_table();
		watch_cycles = 8 + tbl.size() * 40 + 2000 + 3000;
		repeat (8) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		check_reset_state();
		no_wait = 1'b0;
		for (i = 0; i < tbl.size(); i++) begin
			gap = no_wait ? 0 : next_gap();
			repeat (gap) @(posedge clk);
			@(posedge clk);
			apply_entry(tbl[i]);
			no_wait = !tbl[i].wait_busy;
		end
		$display("Simulation completed successfully");
		$finish;
	end

endmodule

/* dv/fm_ctrl_properties.sv */
// FM control block concurrent checks
// Host handshake, slot scan order and timer flag timing

`timescale 1ns/10ps

module fm_ctrl_properties (
	input logic       clk,
	input logic       rst,
	input logic       write,
	input logic       busy,
	input logic [4:0] cur_slot,
	input logic       sample_tick,
	input logic       flag_a,
	input logic       flag_b,
	input logic       irq
);

	// Accepted write holds off the host in the next cycle
	busy_after_write: assert property (@(posedge clk) disable iff (rst)
		write && !busy |=> busy)
		else $error("busy did not rise after an accepted write");

	// Counter leaves zero on the first edge out of reset
	slot_scan: assert property (@(posedge clk) disable iff (rst)
		!rst |=> cur_slot == 5'($past(cur_slot) + 5'd1))
		else $error("cur_slot did not step by one");

	// Flags only change on the sample boundary
	flag_a_on_tick: assert property (@(posedge clk) disable iff (rst)
		$rose(flag_a) |-> $past(sample_tick))
		else $error("flag_a rose outside a sample tick");

	flag_b_on_tick: assert property (@(posedge clk) disable iff (rst)
		$rose(flag_b) |-> $past(sample_tick))
		else $error("flag_b rose outside a sample tick");

	irq_is_or: assert property (@(posedge clk) disable iff (rst)
		irq == (flag_a | flag_b))
		else $error("irq differs from flag_a or flag_b");

endmodule

bind fm_ctrl_top fm_ctrl_properties u_props (
	.clk         (clk),
	.rst         (rst),
	.write       (write),
	.busy        (busy),
	.cur_slot    (cur_slot),
	.sample_tick (sample_tick),
	.flag_a      (flag_a),
	.flag_b      (flag_b),
	.irq         (irq)
);

/* logic/fm_ctrl_top.sv */
// FM control block top level
// Register block beside the slot store and the interval timers

`timescale 1ns/10ps

`include "fm_config.svh"

module fm_ctrl_top import fm_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  logic [7:0] d_in,
	input  logic       write,
	input  logic       a0,
	output logic       busy,
	output logic       ne,
	output logic [4:0] nfrq,
	output logic [7:0] lfo_freq,
	output logic       ct1,
	output logic       ct2,
	output logic [4:0] cur_slot,
	output logic [2:0] con,
	output logic [2:0] fb,
	output logic [6:0] kc,
	output logic [2:0] dt1,
	output logic [3:0] mul,
	output logic [6:0] tl,
	output logic [1:0] ks,
	output logic [4:0] ar,
	output logic       flag_a,
	output logic       flag_b,
	output logic       irq
);

	// Slot update path
	logic       upd;
	field_e     upd_field;
	logic [4:0] upd_slot;
	logic [7:0] upd_data;
	logic       upd_busy;
	logic       sample_tick;

	// Timer control
	logic [`FM_TIMER_A_W-1:0] value_a;
	logic [`FM_TIMER_B_W-1:0] value_b;
	logic                     run_a;
	logic                     run_b;
	logic                     irqen_a;
	logic                     irqen_b;
	logic                     clr_a;
	logic                     clr_b;

	fm_mmr u_mmr (
		.clk       (clk),
		.rst       (rst),
		.d_in      (d_in),
		.write     (write),
		.a0        (a0),
		.upd_busy  (upd_busy),
		.busy      (busy),
		.ne        (ne),
		.nfrq      (nfrq),
		.lfo_freq  (lfo_freq),
		.ct1       (ct1),
		.ct2       (ct2),
		.upd       (upd),
		.upd_field (upd_field),
		.upd_slot  (upd_slot),
		.upd_data  (upd_data),
		.value_a   (value_a),
		.value_b   (value_b),
		.run_a     (run_a),
		.run_b     (run_b),
		.irqen_a   (irqen_a),
		.irqen_b   (irqen_b),
		.clr_a     (clr_a),
		.clr_b     (clr_b)
	);

	fm_slot_regs u_slot_regs (
		.clk         (clk),
		.rst         (rst),
		.upd         (upd),
		.upd_field   (upd_field),
		.upd_slot    (upd_slot),
		.upd_data    (upd_data),
		.upd_busy    (upd_busy),
		.cur_slot    (cur_slot),
		.sample_tick (sample_tick),
		.con         (con),
		.fb          (fb),
		.kc          (kc),
		.dt1         (dt1),
		.mul         (mul),
		.tl          (tl),
		.ks          (ks),
		.ar          (ar)
	);

	fm_timers u_timers (
		.clk         (clk),
		.rst         (rst),
		.sample_tick (sample_tick),
		.value_a     (value_a),
		.value_b     (value_b),
		.run_a       (run_a),
		.run_b       (run_b),
		.irqen_a     (irqen_a),
		.irqen_b     (irqen_b),
		.clr_a       (clr_a),
		.clr_b       (clr_b),
		.flag_a      (flag_a),
		.flag_b      (flag_b),
		.irq         (irq)
	);

endmodule

/* logic/fm_timers.sv */
// FM interval timers
// Timer A counts sample ticks, timer B counts prescaled sample ticks
// Overflow reloads the counter and raises the flag when enabled

`timescale 1ns/10ps

`include "fm_config.svh"

module fm_timers (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     sample_tick,
	input  logic [`FM_TIMER_A_W-1:0] value_a,
	input  logic [`FM_TIMER_B_W-1:0] value_b,
	input  logic                     run_a,
	input  logic                     run_b,
	input  logic                     irqen_a,
	input  logic                     irqen_b,
	input  logic                     clr_a,
	input  logic                     clr_b,
	output logic                     flag_a,
	output logic                     flag_b,
	output logic                     irq
);

	localparam int PW = $clog2(`FM_TIMER_B_PRESCALE);
	localparam logic [PW-1:0] PRESC_LAST = PW'(`FM_TIMER_B_PRESCALE - 1);

	logic [`FM_TIMER_A_W-1:0] cnt_a;
	logic [`FM_TIMER_B_W-1:0] cnt_b;
	logic [PW-1:0]            presc;
	logic                     run_a_d;
	logic                     run_b_d;
	logic                     tick_b;

	assign tick_b = sample_tick && (presc == PRESC_LAST);

	// Free-running prescaler for timer B
	always_ff @(posedge clk) begin
		if (rst)
			presc <= '0;
		else if (sample_tick)
			presc <= (presc == PRESC_LAST) ? '0 : presc + 1'b1;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			cnt_a   <= '0;
			run_a_d <= 1'b0;
			flag_a  <= 1'b0;
		end else begin
			run_a_d <= run_a;
			if (run_a && !run_a_d) begin
				cnt_a <= value_a;
			end else if (run_a && sample_tick) begin
				if (&cnt_a) begin
					cnt_a <= value_a;
					if (irqen_a)
						flag_a <= 1'b1;
				end else begin
					cnt_a <= cnt_a + 1'b1;
				end
			end
			if (clr_a)
				flag_a <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			cnt_b   <= '0;
			run_b_d <= 1'b0;
			flag_b  <= 1'b0;
		end else begin
			run_b_d <= run_b;
			if (run_b && !run_b_d) begin
				cnt_b <= value_b;
			end else if (run_b && tick_b) begin
				if (&cnt_b) begin
					cnt_b <= value_b;
					if (irqen_b)
						flag_b <= 1'b1;
				end else begin
					cnt_b <= cnt_b + 1'b1;
				end
			end
			if (clr_b)
				flag_b <= 1'b0;
		end
	end

	assign irq = flag_a | flag_b;

endmodule

/* logic/fm_slot_regs.sv */
// FM slot parameter store
// Holds per-operator and per-channel parameters, scans the slots
// and applies operator writes when their slot comes round

`timescale 1ns/10ps

`include "fm_config.svh"

module fm_slot_regs import fm_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  logic       upd,
	input  field_e     upd_field,
	input  logic [4:0] upd_slot,
	input  logic [7:0] upd_data,
	output logic       upd_busy,
	output logic [4:0] cur_slot,
	output logic       sample_tick,
	output logic [2:0] con,
	output logic [2:0] fb,
	output logic [6:0] kc,
	output logic [2:0] dt1,
	output logic [3:0] mul,
	output logic [6:0] tl,
	output logic [1:0] ks,
	output logic [4:0] ar
);

	localparam int NCH = 8;

	upd_state_e state;
	field_e     pend_field;
	logic [4:0] pend_slot;
	logic [7:0] pend_data;

	// Operator store, indexed by slot
	logic [2:0] dt1_mem [`FM_SLOTS];
	logic [3:0] mul_mem [`FM_SLOTS];
	logic [6:0] tl_mem  [`FM_SLOTS];
	logic [1:0] ks_mem  [`FM_SLOTS];
	logic [4:0] ar_mem  [`FM_SLOTS];

	// Channel store
	logic [2:0] con_mem [NCH];
	logic [2:0] fb_mem  [NCH];
	logic [6:0] kc_mem  [NCH];

	assign upd_busy    = (state == UPD_WAIT);
	assign sample_tick = (cur_slot == 5'(`FM_SLOTS - 1));

	always_ff @(posedge clk) begin
		if (rst)
			cur_slot <= 5'd0;
		else
			cur_slot <= cur_slot + 5'd1;
	end

	// Channel writes land straight away, operator writes are held
	always_ff @(posedge clk) begin
		if (rst) begin
			state      <= UPD_IDLE;
			pend_field <= FLD_CONFB;
			pend_slot  <= 5'd0;
			pend_data  <= 8'd0;
			for (int i = 0; i < NCH; i++) begin
				con_mem[i] <= 3'd0;
				fb_mem[i]  <= 3'd0;
				kc_mem[i]  <= 7'd0;
			end
		end else begin
			case (state)
				UPD_IDLE: begin
					if (upd) begin
						if (upd_field == FLD_CONFB) begin
							con_mem[upd_slot[2:0]] <= upd_data[2:0];
							fb_mem[upd_slot[2:0]]  <= upd_data[5:3];
						end else if (upd_field == FLD_KC) begin
							kc_mem[upd_slot[2:0]] <= upd_data[6:0];
						end else begin
							pend_field <= upd_field;
							pend_slot  <= upd_slot;
							pend_data  <= upd_data;
							state      <= UPD_WAIT;
						end
					end
				end
				UPD_WAIT: begin
					if (cur_slot == pend_slot)
						state <= UPD_IDLE;
				end
				default: state <= UPD_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `FM_SLOTS; i++) begin
				dt1_mem[i] <= 3'd0;
				mul_mem[i] <= 4'd0;
				tl_mem[i]  <= 7'd0;
				ks_mem[i]  <= 2'd0;
				ar_mem[i]  <= 5'd0;
			end
		end else if (state == UPD_WAIT && cur_slot == pend_slot) begin
			case (pend_field)
				FLD_DT1MUL: begin
					dt1_mem[pend_slot] <= pend_data[6:4];
					mul_mem[pend_slot] <= pend_data[3:0];
				end
				FLD_TL: tl_mem[pend_slot] <= pend_data[6:0];
				FLD_KSAR: begin
					ks_mem[pend_slot] <= pend_data[7:6];
					ar_mem[pend_slot] <= pend_data[4:0];
				end
				default: ;
			endcase
		end
	end

	// Parameters for the slot being scanned
	assign dt1 = dt1_mem[cur_slot];
	assign mul = mul_mem[cur_slot];
	assign tl  = tl_mem[cur_slot];
	assign ks  = ks_mem[cur_slot];
	assign ar  = ar_mem[cur_slot];
	assign con = con_mem[cur_slot[2:0]];
	assign fb  = fb_mem[cur_slot[2:0]];
	assign kc  = kc_mem[cur_slot[2:0]];

endmodule

/* logic/fm_mmr.sv */
// FM register block
// Decodes host bus writes, holds the global and timer registers
// and issues parameter updates to the slot store

`timescale 1ns/10ps

`include "fm_config.svh"

module fm_mmr import fm_pkg::*; (
	input  logic                     clk,
	input  logic                     rst,
	input  logic [7:0]               d_in,
	input  logic                     write,
	input  logic                     a0,
	input  logic                     upd_busy,
	output logic                     busy,
	output logic                     ne,
	output logic [4:0]               nfrq,
	output logic [7:0]               lfo_freq,
	output logic                     ct1,
	output logic                     ct2,
	output logic                     upd,
	output field_e                   upd_field,
	output logic [4:0]               upd_slot,
	output logic [7:0]               upd_data,
	output logic [`FM_TIMER_A_W-1:0] value_a,
	output logic [`FM_TIMER_B_W-1:0] value_b,
	output logic                     run_a,
	output logic                     run_b,
	output logic                     irqen_a,
	output logic                     irqen_b,
	output logic                     clr_a,
	output logic                     clr_b
);

	logic [7:0] sel_addr;
	logic       busy_own;
	logic       accept;
	reg_group_e sel_group;
	field_e     sel_field;
	logic       sel_valid;

	assign accept = write && !busy;

	// Slot store keeps the host waiting while an operator write is pending
	assign busy = busy_own | upd_busy;

	always_comb begin
		if (sel_addr < 8'h20)
			sel_group = GRP_GLOBAL;
		else if (sel_addr < 8'h40)
			sel_group = GRP_CHANNEL;
		else if (sel_addr < 8'hA0)
			sel_group = GRP_OPERATOR;
		else
			sel_group = GRP_NONE;
	end

	// Field behind a channel or operator address
	always_comb begin
		sel_field = FLD_CONFB;
		sel_valid = 1'b0;
		case (sel_group)
			GRP_CHANNEL: begin
				case (sel_addr[4:3])
					2'd0: begin
						sel_field = FLD_CONFB;
						sel_valid = 1'b1;
					end
					2'd1: begin
						sel_field = FLD_KC;
						sel_valid = 1'b1;
					end
					default: sel_valid = 1'b0;
				endcase
			end
			GRP_OPERATOR: begin
				case (sel_addr[7:5])
					3'd2: sel_field = FLD_DT1MUL;
					3'd3: sel_field = FLD_TL;
					default: sel_field = FLD_KSAR;
				endcase
				sel_valid = 1'b1;
			end
			default: sel_valid = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			sel_addr  <= 8'd0;
			busy_own  <= 1'b0;
			upd       <= 1'b0;
			upd_field <= FLD_CONFB;
			upd_slot  <= 5'd0;
			upd_data  <= 8'd0;
			ne        <= 1'b0;
			nfrq      <= 5'd0;
			lfo_freq  <= 8'd0;
			{ct2, ct1} <= 2'd0;
			value_a   <= '0;
			value_b   <= '0;
			{irqen_b, irqen_a, run_b, run_a} <= 4'd0;
			{clr_b, clr_a} <= 2'd0;
		end else begin
			busy_own <= accept;
			// One-shot strobes
			upd   <= 1'b0;
			clr_a <= 1'b0;
			clr_b <= 1'b0;
			if (accept) begin
				if (!a0) begin
					sel_addr <= d_in;
				end else begin
					case (sel_group)
						GRP_GLOBAL: begin
							case (sel_addr)
								REG_NOISE: {ne, nfrq} <= {d_in[7], d_in[4:0]};
								REG_CLKA1: value_a[9:2] <= d_in;
								REG_CLKA2: value_a[1:0] <= d_in[1:0];
								REG_CLKB:  value_b <= d_in;
								REG_TIMER: begin
									{irqen_b, irqen_a, run_b, run_a} <= d_in[3:0];
									{clr_b, clr_a} <= d_in[5:4];
								end
								REG_LFRQ:  lfo_freq <= d_in;
								REG_CTW:   {ct2, ct1} <= d_in[7:6];
								default: ;
							endcase
						end
						GRP_CHANNEL, GRP_OPERATOR: begin
							// Unmapped channel addresses fall through silently
							if (sel_valid) begin
								upd       <= 1'b1;
								upd_field <= sel_field;
								upd_slot  <= sel_addr[4:0];
								upd_data  <= d_in;
							end
						end
						default: ;
					endcase
				end
			end
		end
	end

endmodule

/* logic/fm_pkg.sv */
// FM control block types
// Register groups, slot store fields and update states

package fm_pkg;

	// Address class of the selected register
	typedef enum logic [1:0] {
		GRP_GLOBAL,
		GRP_CHANNEL,
		GRP_OPERATOR,
		GRP_NONE
	} reg_group_e;

	// Parameter carried by a slot store update
	typedef enum logic [2:0] {
		FLD_CONFB,
		FLD_KC,
		FLD_DT1MUL,
		FLD_TL,
		FLD_KSAR
	} field_e;

	typedef enum logic {
		UPD_IDLE,
		UPD_WAIT
	} upd_state_e;

	// Global register addresses
	typedef enum logic [7:0] {
		REG_NOISE = 8'h0F,
		REG_CLKA1 = 8'h10,
		REG_CLKA2 = 8'h11,
		REG_CLKB  = 8'h12,
		REG_TIMER = 8'h14,
		REG_LFRQ  = 8'h18,
		REG_CTW   = 8'h1B
	} reg_addr_e;

endpackage

/* logic/fm_config.svh */
// FM sound generator control block configuration
// Slot scan length and interval timer dimensions

`ifndef FM_CONFIG_SVH
`define FM_CONFIG_SVH

// Slots per sample, four operators times eight channels
`define FM_SLOTS 32

// Timer A counter width, loaded from CLKA1/CLKA2
`define FM_TIMER_A_W 10

// Timer B counter width, loaded from CLKB
`define FM_TIMER_B_W 8

// Sample ticks per timer B tick
`define FM_TIMER_B_PRESCALE 16

`endif
